// File: compile.f
+incdir+hdl
hdl/bus_host_pkg.sv
hdl/request_fifo.sv
hdl/apb_host_master.sv
hdl/apb_swap_regbank.sv
hdl/bus_host_top.sv
tb/tb_bus_host.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bus host testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_bus_host

rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module tb_bus_host -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

grep -q "^Testbench passed$" "$LOG"
if [ $? -ne 0 ]; then
    echo "simulation result: fail"
    exit 1
fi

echo "simulation result: pass"
exit 0

// File: tb/tb_bus_host.sv
////////////////////
// Bus host testbench
// Table-driven swap writes checked against a slot model
////////////////////

`timescale 1ns/1ps

`include "bus_host_defines.svh"

module tb_bus_host;

    import bus_host_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int NUM_DIRECTED   = 10;
    localparam int BURST_LEN      = 12;
    localparam int NUM_ENTRIES    = NUM_DIRECTED + BURST_LEN;
    localparam int MARGIN         = 200;
    localparam int TIMEOUT_CYCLES =
        NUM_ENTRIES * (8 + `BH_WAIT_STATES) + RESET_CYCLES + MARGIN;

    logic  clk;
    logic  rst;
    logic  req_valid;
    logic  req_ready;
    sel_t  req_sel;
    data_t req_data;
    logic  resp_valid;
    data_t resp_data;
    logic  resp_err;

    // Stimulus table, gap is idle cycles after acceptance
    sel_t  tbl_sel  [NUM_ENTRIES];
    data_t tbl_data [NUM_ENTRIES];
    int    tbl_gap  [NUM_ENTRIES];

    data_t model [`BH_SLAVE_COUNT];   // Predicted slot contents
    data_t exp_data_q [$];
    logic  exp_err_q  [$];

    int stall_cycles = 0;   // Cycles with a request held off by a full FIFO
    int cycle_count  = 0;

    bus_host_top uut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_sel    (req_sel),
        .req_data   (req_data),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_err   (resp_err)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_data(input data_t exp, input data_t act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] resp_data expected 0x%08h actual 0x%08h", exp, act));
        end
    endtask

    task automatic check_err(input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] resp_err expected 0x%0h actual 0x%0h", exp, act));
        end
    endtask

    // Single-bit handshake outputs
    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act));
        end
    endtask

    task automatic set_row(input int idx, input sel_t sel, input data_t data, input int gap);
        tbl_sel[idx]  = sel;
        tbl_data[idx] = data;
        tbl_gap[idx]  = gap;
    endtask

    task automatic load_table();
        // First touch of each slot returns its reset word
        set_row(0, 2'd0, 32'h1111_1111, 6);
        set_row(1, 2'd1, 32'h2222_2222, 6);
        set_row(2, 2'd2, 32'h3333_3333, 6);
        // Second touch returns the previous write
        set_row(3, 2'd0, 32'h4444_4444, 6);
        set_row(4, 2'd1, 32'h5555_5555, 6);
        set_row(5, 2'd3, 32'hDEAD_BEEF, 6);   // Out of range
        set_row(6, 2'd2, 32'h6666_6666, 6);
        set_row(7, 2'd3, 32'h0BAD_F00D, 2);
        set_row(8, 2'd0, 32'h7777_7777, 0);
        set_row(9, 2'd1, 32'h8888_8888, 6);
        // Back-to-back burst to fill the queue
        for (int i = NUM_DIRECTED; i < NUM_ENTRIES; i++) begin
            set_row(i, sel_t'($urandom % 4), data_t'($urandom), 0);
        end
    endtask

    // Slot k starts at base plus k times 0x1000
    task automatic reset_model();
        for (int k = 0; k < `BH_SLAVE_COUNT; k++) begin
            model[k] = `BH_RESET_BASE + data_t'(k) * 32'h1000;
        end
    endtask

    task automatic predict(input sel_t sel, input data_t data);
        if (int'(sel) < `BH_SLAVE_COUNT) begin
            exp_data_q.push_back(model[sel]);
            exp_err_q.push_back(1'b0);
            model[sel] = data;
        end else begin
            exp_data_q.push_back('0);
            exp_err_q.push_back(1'b1);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_request(input sel_t sel, input data_t data);
        logic taken;
        taken     = 1'b0;
        req_valid = 1'b1;
        req_sel   = sel;
        req_data  = data;
        while (!taken) begin
            if (req_ready) begin
                predict(sel, data);
                taken = 1'b1;
            end else begin
                stall_cycles++;
            end
            @(negedge clk);
        end
        req_valid = 1'b0;
    endtask

    // Response checker, resp_valid is stable at the falling edge
    always @(negedge clk) begin
        if (resp_valid === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                abort_run("response pulse seen with no request outstanding");
            end else begin
                check_data(exp_data_q.pop_front(), resp_data);
                check_err(exp_err_q.pop_front(), resp_err);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles, run did not finish", cycle_count));
        end
    end

    initial begin
        void'($urandom(43555));
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_sel   = '0;
        req_data  = '0;
        reset_model();
        load_table();

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag("resp_valid", 1'b0, resp_valid);
        check_flag("req_ready", 1'b1, req_ready);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            send_request(tbl_sel[i], tbl_data[i]);
            repeat (tbl_gap[i]) @(negedge clk);
        end

        while (exp_data_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);   // Quiet window for stray responses

        if (stall_cycles == 0) begin
            abort_run("req_ready never dropped, the burst did not fill the request FIFO");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: hdl/bus_host_top.sv
////////////////////
// Bus host top
// Request FIFO feeding the APB host master and swap bank
////////////////////

`timescale 1ns/1ps

module bus_host_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    output logic                req_ready,
    input  bus_host_pkg::sel_t  req_sel,
    input  bus_host_pkg::data_t req_data,
    output logic                resp_valid,
    output bus_host_pkg::data_t resp_data,
    output logic                resp_err
);

    import bus_host_pkg::*;

    logic  push;
    logic  fifo_full;
    logic  fifo_empty;
    logic  fifo_pop;
    sel_t  fifo_sel;
    data_t fifo_data;

    // APB wires
    logic  psel;
    logic  penable;
    logic  pwrite;
    sel_t  paddr;
    data_t pwdata;
    data_t prdata;
    logic  pready;
    logic  pslverr;

    assign req_ready = ~fifo_full;   // Only back-pressure source
    assign push      = req_valid & req_ready;

    request_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_sel  (req_sel),
        .push_data (req_data),
        .pop       (fifo_pop),
        .head_sel  (fifo_sel),
        .head_data (fifo_data),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    apb_host_master u_master (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (fifo_empty),
        .fifo_sel   (fifo_sel),
        .fifo_data  (fifo_data),
        .fifo_pop   (fifo_pop),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .resp_err   (resp_err)
    );

    apb_swap_regbank u_bank (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

endmodule

// File: hdl/apb_swap_regbank.sv
////////////////////
// APB swap register bank
// Write returns the previous slot word, bad select errors out
////////////////////

`timescale 1ns/1ps

`include "bus_host_defines.svh"

module apb_swap_regbank (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  bus_host_pkg::sel_t  paddr,
    input  bus_host_pkg::data_t pwdata,
    output bus_host_pkg::data_t prdata,
    output logic                pready,
    output logic                pslverr
);

    import bus_host_pkg::*;

    localparam int NSLOT = `BH_SLAVE_COUNT;
    localparam int NWAIT = `BH_WAIT_STATES;
    localparam int CW    = (NWAIT > 0) ? $clog2(NWAIT + 1) : 1;

    data_t slots [NSLOT];

    bank_state_t     bank_state;
    logic [CW-1:0]   wait_cnt;   // Access cycles still to stall

    logic setup_ph;
    logic access_ph;
    logic sel_ok;
    logic xfer_done;

    assign setup_ph  = psel && !penable;
    assign access_ph = psel && penable;
    assign sel_ok    = (int'(paddr) < NSLOT);
    assign xfer_done = access_ph && pready;

    // Counter armed in SETUP, runs down through ACCESS
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_state <= WAIT;
            wait_cnt   <= '0;
        end else if (setup_ph) begin
            bank_state <= (NWAIT == 0) ? READY : WAIT;
            wait_cnt   <= CW'(NWAIT);
        end else if (xfer_done) begin
            bank_state <= WAIT;
        end else if (access_ph && bank_state == WAIT) begin
            if (wait_cnt == CW'(1)) begin
                bank_state <= READY;
            end
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign pready  = access_ph && (bank_state == READY);
    assign prdata  = sel_ok ? slots[paddr] : '0;
    assign pslverr = pready && !sel_ok;

    // Slots reset to base plus index times 0x1000
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < NSLOT; k++) begin
                slots[k] <= data_t'(`BH_RESET_BASE + k * 32'h1000);
            end
        end else if (xfer_done && pwrite && sel_ok) begin
            slots[paddr] <= pwdata;
        end
    end

endmodule

// File: hdl/apb_host_master.sv
////////////////////
// APB host master
// Replays queued requests as APB writes, one response pulse each
////////////////////

`timescale 1ns/1ps

module apb_host_master (
    input  logic                clk,
    input  logic                rst,
    // Request queue side
    input  logic                fifo_empty,
    input  bus_host_pkg::sel_t  fifo_sel,
    input  bus_host_pkg::data_t fifo_data,
    output logic                fifo_pop,
    // APB side
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output bus_host_pkg::sel_t  paddr,
    output bus_host_pkg::data_t pwdata,
    input  bus_host_pkg::data_t prdata,
    input  logic                pready,
    input  logic                pslverr,
    // Response side
    output logic                resp_valid,
    output bus_host_pkg::data_t resp_data,
    output logic                resp_err
);

    import bus_host_pkg::*;

    host_state_t state;
    host_state_t state_nxt;

    sel_t  sel_q;     // Held through both phases
    data_t data_q;
    data_t rdata_q;
    logic  err_q;

    logic xfer_done;

    assign xfer_done = (state == ACCESS) && pready;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (!fifo_empty) begin
                    state_nxt = SETUP;
                end
            end
            SETUP:   state_nxt = ACCESS;
            ACCESS: begin
                if (pready) begin
                    state_nxt = RESPOND;
                end
            end
            RESPOND: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Head entry taken as IDLE is left
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            sel_q  <= fifo_sel;
            data_q <= fifo_data;
        end
    end

    // Completion edge captures the old slot word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            err_q <= 1'b0;
        end else if (xfer_done) begin
            err_q <= pslverr;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_done) begin
            rdata_q <= pslverr ? '0 : prdata;   // Zero word on error
        end
    end

    assign fifo_pop = (state == IDLE) && !fifo_empty;

    assign psel    = (state == SETUP) || (state == ACCESS);
    assign penable = (state == ACCESS);
    assign pwrite  = 1'b1;    // Every transfer is a swap write
    assign paddr   = sel_q;
    assign pwdata  = data_q;

    assign resp_valid = (state == RESPOND);
    assign resp_data  = rdata_q;
    assign resp_err   = err_q;

endmodule

// File: hdl/request_fifo.sv
////////////////////
// Request FIFO
// Queues select and data pairs, head entry always visible
////////////////////

`timescale 1ns/1ps

`include "bus_host_defines.svh"

module request_fifo (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  bus_host_pkg::sel_t  push_sel,
    input  bus_host_pkg::data_t push_data,
    input  logic                pop,
    output bus_host_pkg::sel_t  head_sel,
    output bus_host_pkg::data_t head_data,
    output logic                full,
    output logic                empty
);

    import bus_host_pkg::*;

    localparam int DEPTH = `BH_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    sel_t  sel_mem  [DEPTH];
    data_t data_mem [DEPTH];

    // Extra MSB tells a full ring from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign head_sel  = sel_mem[rd_ptr[AW-1:0]];
    assign head_data = data_mem[rd_ptr[AW-1:0]];

    // Storage, written at the tail
    always_ff @(posedge clk) begin
        if (do_push) begin
            sel_mem[wr_ptr[AW-1:0]]  <= push_sel;
            data_mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Head advances on pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// File: hdl/bus_host_pkg.sv
////////////////////
// Bus host shared types
////////////////////

package bus_host_pkg;

    // Bus data word
    typedef logic [31:0] data_t;

    // Slot select, also used as the APB address
    typedef logic [1:0] sel_t;

    // APB host master sequencing
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESPOND
    } host_state_t;

    // Completer wait-state tracking
    typedef enum logic {
        WAIT,
        READY
    } bank_state_t;

endpackage

// File: hdl/bus_host_defines.svh
////////////////////
// Bus host build constants
// Slot count, request queue depth, completer wait states, slot reset base
////////////////////

`ifndef BUS_HOST_DEFINES_SVH
`define BUS_HOST_DEFINES_SVH

// Slots present in the register bank, so select 3 is out of range
`define BH_SLAVE_COUNT 3

// Pending request entries, must be a power of two
`define BH_FIFO_DEPTH 4

// Access cycles with PREADY low before completion, zero allowed
`define BH_WAIT_STATES 1

// Slot 0 reset word, each later slot adds 0x1000
`define BH_RESET_BASE 32'h89AB_CDEF

`endif
